// ==== run_sim.sh ====
#!/bin/bash
# Build and run the pg_unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module pg_unit_tb -o pg_unit_sim \
   && ./obj_dir/pg_unit_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== source/pg_delay_timer.sv ====
`timescale 1ns/100ps

module pg_delay_timer (
   input  logic                                 clk,
   input  logic                                 rst_n,
   // Load pulse, takes effect on the next edge
   input  logic                                 tmr_load,
   input  logic [pg_timing_pkg::DLY_CODE_W-1:0] tmr_code,
   // High while the count sits at zero
   output logic                                 tmr_done
);

   // Remaining wait cycles
   logic [pg_timing_pkg::TMR_W-1:0] cnt;

   // ----------------------------
   // Down counter
   // ----------------------------

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Idle timer reads as expired
         cnt <= '0;
      end else if (tmr_load) begin
         // Code picks the wait length from the table
         cnt <= pg_timing_pkg::DLY_CYCLES[tmr_code];
      end else if (cnt != '0) begin
         cnt <= cnt - 1'b1;
      end
   end

   // Stays high at zero until the next load
   assign tmr_done = (cnt == '0);

endmodule

// ==== source/pg_dfx_ovr.sv ====
`timescale 1ns/100ps

module pg_dfx_ovr (
   input  logic       clk,
   input  logic       rst_n,
   // Controls from the sequencer FSM
   input  logic       fsm_sleep,
   input  logic       fsm_isol_en_b,
   input  logic       fsm_isol_latchen,
   input  logic       fsm_force_rst_b,
   input  logic       fsm_pok,
   input  logic       fsm_pwrgate_active,
   input  logic       pmc_fet_en_b,
   // DFx bypass, ovr picks power-up or power-down
   input  logic       fdfx_bypass,
   input  logic       fdfx_ovr,
   // Scan forcing of isolation, latch and sleep
   input  logic       fscan_mode,
   input  logic       fscan_isol_ctrl,
   input  logic       fscan_isol_lat_ctrl,
   input  logic       fscan_ret_ctrl,
   output logic       sleep,
   output logic       isol_en_b,
   output logic       isol_latchen,
   output logic       force_rst_b,
   output logic       pok,
   output logic       pwrgate_active,
   output logic       fet_en_b,
   output logic [1:0] dfx_state
);

   pg_types_pkg::dfx_state_e        dfx_q;
   logic [pg_timing_pkg::TMR_W-1:0] step_cnt;
   logic                            at_target;
   logic                            step;

   // ----------------------------
   // Bypass sequencer
   // ----------------------------

   assign at_target = fdfx_ovr ? (dfx_q == pg_types_pkg::DFX_ON) :
                                 (dfx_q == pg_types_pkg::DFX_OFF);

   // One state move per step period
   assign step = fdfx_bypass && !at_target &&
                 (step_cnt == pg_timing_pkg::DFX_STEP_CYCLES - 1'b1);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         // Powered on, so leaving bypass changes nothing
         dfx_q    <= pg_types_pkg::DFX_ON;
         step_cnt <= '0;
      end else if (!fdfx_bypass || at_target) begin
         step_cnt <= '0;
      end else if (step) begin
         step_cnt <= '0;
         dfx_q    <= fdfx_ovr ? pg_types_pkg::dfx_state_e'(dfx_q + 2'd1) :
                                pg_types_pkg::dfx_state_e'(dfx_q - 2'd1);
      end else begin
         step_cnt <= step_cnt + 1'b1;
      end
   end

   // ----------------------------
   // Output muxing
   // ----------------------------

   always_comb begin
      if (fdfx_bypass) begin
         // FET on first, then isolation and sleep released, then reset and pok
         fet_en_b       = (dfx_q == pg_types_pkg::DFX_OFF);
         isol_en_b      = dfx_q inside {pg_types_pkg::DFX_UNISOL, pg_types_pkg::DFX_ON};
         sleep          = !(dfx_q inside {pg_types_pkg::DFX_UNISOL, pg_types_pkg::DFX_ON});
         isol_latchen   = 1'b0;
         force_rst_b    = (dfx_q == pg_types_pkg::DFX_ON);
         pok            = (dfx_q == pg_types_pkg::DFX_ON);
         pwrgate_active = (dfx_q != pg_types_pkg::DFX_ON);
      end else begin
         fet_en_b       = pmc_fet_en_b;
         isol_en_b      = fsm_isol_en_b;
         sleep          = fsm_sleep;
         isol_latchen   = fsm_isol_latchen;
         force_rst_b    = fsm_force_rst_b;
         pok            = fsm_pok;
         pwrgate_active = fsm_pwrgate_active;
      end
      // Scan wins over both sources
      if (fscan_mode) begin
         isol_en_b    = fscan_isol_ctrl;
         isol_latchen = fscan_isol_lat_ctrl;
         sleep        = fscan_ret_ctrl;
      end
   end

   assign dfx_state = dfx_q;

endmodule

// ==== source/pg_seq_fsm.sv ====
`timescale 1ns/100ps

module pg_seq_fsm (
   input  logic                   clk,
   input  logic                   rst_n,
   // IP handshake
   input  logic                   ip_pg_rdy_req_b,
   input  pg_types_pkg::pg_type_e ip_pg_type,
   // PMC handshake
   input  logic                   pmc_pg_ack_b,
   // Step delay codes
   input  logic [1:0]             cfg_trstdown,
   input  logic [1:0]             cfg_tisolate,
   input  logic [1:0]             cfg_tsleepact,
   input  logic [1:0]             cfg_tsleepinactiv,
   input  logic [1:0]             cfg_tdeisolate,
   input  logic [1:0]             cfg_trstup,
   output logic                   pmc_pg_req_b,
   output logic                   pg_rdy_ack_b,
   output logic                   idle,
   // Partition controls before DFx override
   output logic                   fsm_sleep,
   output logic                   fsm_isol_en_b,
   output logic                   fsm_isol_latchen,
   output logic                   fsm_force_rst_b,
   output logic                   fsm_pok,
   output logic                   fsm_pwrgate_active,
   output logic [3:0]             fsm_state
);

   pg_types_pkg::pg_state_e state;
   pg_types_pkg::pg_state_e state_nxt;

   // Type captured at the start of power-down
   pg_types_pkg::pg_type_e type_q;

   logic                                 warm;
   logic                                 acc;
   logic                                 nxt_timed;
   logic                                 tmr_load;
   logic [pg_timing_pkg::DLY_CODE_W-1:0] tmr_code;
   logic                                 tmr_done;

   assign warm = (type_q == pg_types_pkg::PG_WARM);
   assign acc  = (type_q == pg_types_pkg::PG_ACC);

   // ----------------------------
   // Next state
   // ----------------------------

   always_comb begin
      state_nxt = state;
      case (state)
         pg_types_pkg::ST_ON: begin
            if (!ip_pg_rdy_req_b) state_nxt = pg_types_pkg::ST_RST_DOWN;
         end
         pg_types_pkg::ST_RST_DOWN: begin
            if (tmr_done) state_nxt = pg_types_pkg::ST_ISOLATE;
         end
         pg_types_pkg::ST_ISOLATE: begin
            // Warm reset stops here with power kept on
            if (tmr_done) begin
               state_nxt = warm ? pg_types_pkg::ST_OFF : pg_types_pkg::ST_SLEEP_ACT;
            end
         end
         pg_types_pkg::ST_SLEEP_ACT: begin
            if (tmr_done) state_nxt = pg_types_pkg::ST_PMC_REQ;
         end
         pg_types_pkg::ST_PMC_REQ: begin
            // Held here until the PMC grants the gate
            if (!pmc_pg_ack_b) state_nxt = pg_types_pkg::ST_OFF;
         end
         pg_types_pkg::ST_OFF: begin
            if (ip_pg_rdy_req_b) begin
               state_nxt = warm ? pg_types_pkg::ST_DEISOLATE : pg_types_pkg::ST_PMC_REL;
            end
         end
         pg_types_pkg::ST_PMC_REL: begin
            // Power back once the ack is withdrawn
            if (pmc_pg_ack_b) state_nxt = pg_types_pkg::ST_SLEEP_INACT;
         end
         pg_types_pkg::ST_SLEEP_INACT: begin
            if (tmr_done) state_nxt = pg_types_pkg::ST_DEISOLATE;
         end
         pg_types_pkg::ST_DEISOLATE: begin
            if (tmr_done) state_nxt = pg_types_pkg::ST_RST_UP;
         end
         pg_types_pkg::ST_RST_UP: begin
            if (tmr_done) state_nxt = pg_types_pkg::ST_ON;
         end
         default: state_nxt = pg_types_pkg::ST_ON;
      endcase
   end

   // ----------------------------
   // Step timer
   // ----------------------------

   // Code of the state about to be entered
   always_comb begin
      nxt_timed = 1'b1;
      tmr_code  = cfg_trstdown;
      case (state_nxt)
         pg_types_pkg::ST_RST_DOWN:    tmr_code = cfg_trstdown;
         pg_types_pkg::ST_ISOLATE:     tmr_code = cfg_tisolate;
         pg_types_pkg::ST_SLEEP_ACT:   tmr_code = cfg_tsleepact;
         pg_types_pkg::ST_SLEEP_INACT: tmr_code = cfg_tsleepinactiv;
         pg_types_pkg::ST_DEISOLATE:   tmr_code = cfg_tdeisolate;
         pg_types_pkg::ST_RST_UP:      tmr_code = cfg_trstup;
         default:                      nxt_timed = 1'b0;
      endcase
   end

   // Counter loads on the entry edge, so done is low in the first cycle
   assign tmr_load = nxt_timed && (state_nxt != state);

   pg_delay_timer i_delay_timer (
      .clk      (clk),
      .rst_n    (rst_n),
      .tmr_load (tmr_load),
      .tmr_code (tmr_code),
      .tmr_done (tmr_done)
   );

   // ----------------------------
   // State and outputs
   // ----------------------------

   // Outputs decode the next state so each change lands on the step edge
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state            <= pg_types_pkg::ST_ON;
         type_q           <= pg_types_pkg::PG_INACC;
         fsm_pok          <= 1'b1;
         fsm_isol_en_b    <= 1'b1;
         fsm_force_rst_b  <= 1'b1;
         fsm_sleep        <= 1'b0;
         fsm_isol_latchen <= 1'b0;
         pmc_pg_req_b     <= 1'b1;
         pg_rdy_ack_b     <= 1'b1;
         idle             <= 1'b1;
      end else begin
         state <= state_nxt;
         // Type frozen for the whole flow, reserved folds to inaccessible
         if (state == pg_types_pkg::ST_ON && !ip_pg_rdy_req_b) begin
            type_q <= (ip_pg_type == pg_types_pkg::PG_RSVD) ?
                      pg_types_pkg::PG_INACC : ip_pg_type;
         end
         fsm_pok         <= (state_nxt == pg_types_pkg::ST_ON);
         fsm_force_rst_b <= state_nxt inside {pg_types_pkg::ST_ON, pg_types_pkg::ST_RST_DOWN};
         fsm_isol_en_b   <= state_nxt inside {pg_types_pkg::ST_ON, pg_types_pkg::ST_RST_DOWN,
                                              pg_types_pkg::ST_ISOLATE, pg_types_pkg::ST_RST_UP};
         // Warm off keeps the rail up
         fsm_sleep <= (state_nxt inside {pg_types_pkg::ST_PMC_REQ, pg_types_pkg::ST_PMC_REL,
                                         pg_types_pkg::ST_SLEEP_INACT}) ||
                      (state_nxt == pg_types_pkg::ST_OFF && !warm);
         // Retention latches closed around the sleep window, accessible type only
         fsm_isol_latchen <= acc &&
                             (state_nxt inside {pg_types_pkg::ST_SLEEP_ACT,
                                                pg_types_pkg::ST_PMC_REQ,
                                                pg_types_pkg::ST_OFF,
                                                pg_types_pkg::ST_PMC_REL,
                                                pg_types_pkg::ST_SLEEP_INACT});
         pmc_pg_req_b <= !((state_nxt == pg_types_pkg::ST_PMC_REQ) ||
                           (state_nxt == pg_types_pkg::ST_OFF && !warm));
         // Ack drops at off and stays low until power-up completes
         pg_rdy_ack_b <= state_nxt inside {pg_types_pkg::ST_ON, pg_types_pkg::ST_RST_DOWN,
                                           pg_types_pkg::ST_ISOLATE,
                                           pg_types_pkg::ST_SLEEP_ACT,
                                           pg_types_pkg::ST_PMC_REQ};
         idle <= state_nxt inside {pg_types_pkg::ST_ON, pg_types_pkg::ST_OFF};
      end
   end

   // Flow in progress, straight from the state register
   assign fsm_pwrgate_active = !(state inside {pg_types_pkg::ST_ON, pg_types_pkg::ST_OFF});

   assign fsm_state = state;

endmodule

// ==== source/pg_timing_pkg.sv ====
package pg_timing_pkg;

   // ----------------------------
   // Step timing
   // ----------------------------

   // Delay code width on every cfg_t* input
   localparam int DLY_CODE_W = 2;

   // Timer counter width, must hold the largest table entry
   localparam int TMR_W = 7;

   // Wait cycles per delay code
   // Code 0 is the shortest step, code 3 the longest
   localparam logic [TMR_W-1:0] DLY_CYCLES [2**DLY_CODE_W] = '{
      TMR_W'(1),
      TMR_W'(4),
      TMR_W'(16),
      TMR_W'(64)
   };

   // Cycles spent in each DFx sequencer state while stepping
   localparam logic [TMR_W-1:0] DFX_STEP_CYCLES = TMR_W'(4);

endpackage

// ==== source/pg_types_pkg.sv ====
package pg_types_pkg;

   // ----------------------------
   // Sequencer states
   // ----------------------------

   // Down flow runs top to bottom up to ST_OFF, up flow runs back out
   typedef enum logic [3:0] {
      // Partition powered and out of reset
      ST_ON,
      // Reset asserted to the partition
      ST_RST_DOWN,
      // Isolation cells closing
      ST_ISOLATE,
      // Retention sleep asserting
      ST_SLEEP_ACT,
      // Power-gate request to PMC, wait for ack
      ST_PMC_REQ,
      // Partition gated, wait for IP wake request
      ST_OFF,
      // PMC request released, wait for ack release
      ST_PMC_REL,
      // Retention sleep releasing
      ST_SLEEP_INACT,
      // Isolation cells opening
      ST_DEISOLATE,
      // Reset release to the partition
      ST_RST_UP
   } pg_state_e;

   // Power-gate flavour requested by the IP
   typedef enum logic [1:0] {
      PG_ACC   = 2'd0,
      PG_WARM  = 2'd1,
      // Handled as inaccessible
      PG_RSVD  = 2'd2,
      PG_INACC = 2'd3
   } pg_type_e;

   // DFx bypass sequencer, ordered from gated to powered
   typedef enum logic [1:0] {
      DFX_OFF,
      DFX_FET_ON,
      DFX_UNISOL,
      DFX_ON
   } dfx_state_e;

   // Visibility bus width
   localparam int VISA_W = 16;

endpackage

// ==== source/pg_unit.sv ====
`timescale 1ns/100ps

module pg_unit (
   input  logic                            clk,
   input  logic                            rst_n,
   // IP handshake
   input  logic                            ip_pg_rdy_req_b,
   input  logic [1:0]                      ip_pg_type,
   // PMC handshake
   input  logic                            pmc_pg_ack_b,
   input  logic                            pmc_fet_en_b,
   // Step delay codes
   input  logic [1:0]                      cfg_trstdown,
   input  logic [1:0]                      cfg_tisolate,
   input  logic [1:0]                      cfg_tsleepact,
   input  logic [1:0]                      cfg_tsleepinactiv,
   input  logic [1:0]                      cfg_tdeisolate,
   input  logic [1:0]                      cfg_trstup,
   // DFx and scan controls
   input  logic                            fdfx_bypass,
   input  logic                            fdfx_ovr,
   input  logic                            fscan_mode,
   input  logic                            fscan_isol_ctrl,
   input  logic                            fscan_isol_lat_ctrl,
   input  logic                            fscan_ret_ctrl,
   output logic                            pmc_pg_req_b,
   output logic                            pg_rdy_ack_b,
   output logic                            idle,
   // Partition controls
   output logic                            sleep,
   output logic                            isol_en_b,
   output logic                            isol_latchen,
   output logic                            force_rst_b,
   output logic                            pok,
   output logic                            pwrgate_active,
   output logic                            fet_en_b,
   output logic [pg_types_pkg::VISA_W-1:0] visa
);

   logic       fsm_sleep;
   logic       fsm_isol_en_b;
   logic       fsm_isol_latchen;
   logic       fsm_force_rst_b;
   logic       fsm_pok;
   logic       fsm_pwrgate_active;
   logic [3:0] fsm_state;
   logic [1:0] dfx_state;

   // ----------------------------
   // Sequencer
   // ----------------------------

   pg_seq_fsm i_seq_fsm (
      .clk                (clk),
      .rst_n              (rst_n),
      .ip_pg_rdy_req_b    (ip_pg_rdy_req_b),
      .ip_pg_type         (pg_types_pkg::pg_type_e'(ip_pg_type)),
      .pmc_pg_ack_b       (pmc_pg_ack_b),
      .cfg_trstdown       (cfg_trstdown),
      .cfg_tisolate       (cfg_tisolate),
      .cfg_tsleepact      (cfg_tsleepact),
      .cfg_tsleepinactiv  (cfg_tsleepinactiv),
      .cfg_tdeisolate     (cfg_tdeisolate),
      .cfg_trstup         (cfg_trstup),
      .pmc_pg_req_b       (pmc_pg_req_b),
      .pg_rdy_ack_b       (pg_rdy_ack_b),
      .idle               (idle),
      .fsm_sleep          (fsm_sleep),
      .fsm_isol_en_b      (fsm_isol_en_b),
      .fsm_isol_latchen   (fsm_isol_latchen),
      .fsm_force_rst_b    (fsm_force_rst_b),
      .fsm_pok            (fsm_pok),
      .fsm_pwrgate_active (fsm_pwrgate_active),
      .fsm_state          (fsm_state)
   );

   // DFx override sits between the FSM and the partition
   pg_dfx_ovr i_dfx_ovr (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fsm_sleep           (fsm_sleep),
      .fsm_isol_en_b       (fsm_isol_en_b),
      .fsm_isol_latchen    (fsm_isol_latchen),
      .fsm_force_rst_b     (fsm_force_rst_b),
      .fsm_pok             (fsm_pok),
      .fsm_pwrgate_active  (fsm_pwrgate_active),
      .pmc_fet_en_b        (pmc_fet_en_b),
      .fdfx_bypass         (fdfx_bypass),
      .fdfx_ovr            (fdfx_ovr),
      .fscan_mode          (fscan_mode),
      .fscan_isol_ctrl     (fscan_isol_ctrl),
      .fscan_isol_lat_ctrl (fscan_isol_lat_ctrl),
      .fscan_ret_ctrl      (fscan_ret_ctrl),
      .sleep               (sleep),
      .isol_en_b           (isol_en_b),
      .isol_latchen        (isol_latchen),
      .force_rst_b         (force_rst_b),
      .pok                 (pok),
      .pwrgate_active      (pwrgate_active),
      .fet_en_b            (fet_en_b),
      .dfx_state           (dfx_state)
   );

   // ----------------------------
   // Visibility bus
   // ----------------------------

   // Upper bits spare and tied low
   // Flags at 11:6 show raw FSM values ahead of any override
   assign visa = {{(pg_types_pkg::VISA_W - 12){1'b0}},
                  fsm_pwrgate_active, fsm_pok, fsm_force_rst_b,
                  fsm_isol_latchen, fsm_isol_en_b, fsm_sleep,
                  dfx_state,
                  fsm_state};

endmodule

// ==== tests/pg_unit_chk.sv ====
`timescale 1ns/100ps

module pg_unit_chk (
   input logic       clk,
   input logic       rst_n,
   input logic       sleep,
   input logic       isol_en_b,
   input logic       force_rst_b,
   input logic       pok,
   input logic       fscan_mode,
   input logic       fdfx_bypass,
   input logic       pg_rdy_ack_b,
   input logic       ip_pg_rdy_req_b,
   input logic [1:0] ip_pg_type,
   input logic       pmc_pg_ack_b
);

   // ----------------------------
   // Sequencing invariants
   // ----------------------------

   // Retention sleep only behind closed isolation
   sleep_isolated: assert property (@(posedge clk) disable iff (!rst_n)
      (!fscan_mode && sleep) |-> !isol_en_b)
      else $error("sleep high while isolation open");

   // Power ok means the partition is fully released
   pok_released: assert property (@(posedge clk) disable iff (!rst_n)
      (!fdfx_bypass && !fscan_mode && pok) |-> (isol_en_b && force_rst_b))
      else $error("pok high with isolation or reset asserted");

   // Gated off only after the PMC granted it, while the IP still holds its request
   ack_needs_pmc: assert property (@(posedge clk) disable iff (!rst_n)
      (!pg_rdy_ack_b && !ip_pg_rdy_req_b && ip_pg_type != 2'd1) |-> !pmc_pg_ack_b)
      else $error("ready ack low without PMC ack");

endmodule

bind pg_unit pg_unit_chk pg_unit_chk_inst (
   .clk             (clk),
   .rst_n           (rst_n),
   .sleep           (sleep),
   .isol_en_b       (isol_en_b),
   .force_rst_b     (force_rst_b),
   .pok             (pok),
   .fscan_mode      (fscan_mode),
   .fdfx_bypass     (fdfx_bypass),
   .pg_rdy_ack_b    (pg_rdy_ack_b),
   .ip_pg_rdy_req_b (ip_pg_rdy_req_b),
   .ip_pg_type      (ip_pg_type),
   .pmc_pg_ack_b    (pmc_pg_ack_b)
);

// ==== tests/pg_unit_tb.sv ====
`timescale 1ns/100ps

module pg_unit_tb;

   // Row kinds
   localparam int FLOW = 0;
   localparam int DFX  = 1;
   localparam int SCAN = 2;
   localparam int TMO  = 2000;

   typedef struct packed {
      logic [1:0]  mode;
      logic [1:0]  ptype;
      logic        rnd;
      logic [11:0] cfg;
      logic        byp;
      logic        ovr;
      logic [2:0]  scn;    // isol, lat, ret
      logic [5:0]  exp;    // sleep, isol_en_b, force_rst_b, pok, latchen, fet_en_b
   } row_t;

   logic clk = 1'b0;
   logic rst_n;
   logic ip_pg_rdy_req_b;
   logic [1:0] ip_pg_type;
   logic pmc_pg_ack_b;
   logic pmc_fet_en_b;
   logic [1:0] cfg_trstdown;
   logic [1:0] cfg_tisolate;
   logic [1:0] cfg_tsleepact;
   logic [1:0] cfg_tsleepinactiv;
   logic [1:0] cfg_tdeisolate;
   logic [1:0] cfg_trstup;
   logic fdfx_bypass;
   logic fdfx_ovr;
   logic fscan_mode;
   logic fscan_isol_ctrl;
   logic fscan_isol_lat_ctrl;
   logic fscan_ret_ctrl;
   logic pmc_pg_req_b;
   logic pg_rdy_ack_b;
   logic idle;
   logic sleep;
   logic isol_en_b;
   logic isol_latchen;
   logic force_rst_b;
   logic pok;
   logic pwrgate_active;
   logic fet_en_b;
   logic [15:0] visa;

   row_t rows [10];
   int   errs = 0;
   int   fails = 0;
   int   passes = 0;
   int   pmc_wait = 0;
   int   cyc = 0;
   int   t_rst_fall;
   int   t_isol_fall;
   int   t_sleep_rise;
   int   t_sleep_fall;
   int   t_isol_rise;
   int   t_rst_rise;
   bit   req_seen;
   bit   sleep_seen;
   bit   active_seen;
   logic prev_rst = 1'b1;
   logic prev_isol = 1'b1;
   logic prev_sleep = 1'b0;

   pg_unit pg_unit_inst (.*);

   always #10 clk = ~clk;

   // ----------------------------
   // PMC model
   // ----------------------------

   // Ack follows the request after 1 to 8 cycles, FET off while acked
   always @(posedge clk) begin
      #1;
      if (!rst_n) begin
         pmc_wait = 0;
         pmc_pg_ack_b = 1'b1;
      end else if (pmc_pg_ack_b != pmc_pg_req_b) begin
         if (pmc_wait == 0) begin
            pmc_wait = $urandom_range(1, 8);
         end else begin
            pmc_wait = pmc_wait - 1;
            if (pmc_wait == 0) pmc_pg_ack_b = pmc_pg_req_b;
         end
      end
      pmc_fet_en_b = !pmc_pg_ack_b;
   end

   // Edge recorder for the ordering checks
   always @(negedge clk) begin
      cyc = cyc + 1;
      if (prev_rst && !force_rst_b) t_rst_fall = cyc;
      if (!prev_rst && force_rst_b) t_rst_rise = cyc;
      if (prev_isol && !isol_en_b) t_isol_fall = cyc;
      if (!prev_isol && isol_en_b) t_isol_rise = cyc;
      if (!prev_sleep && sleep) t_sleep_rise = cyc;
      if (prev_sleep && !sleep) t_sleep_fall = cyc;
      if (!pmc_pg_req_b) req_seen = 1'b1;
      if (sleep) sleep_seen = 1'b1;
      if (pwrgate_active) active_seen = 1'b1;
      prev_rst = force_rst_b;
      prev_isol = isol_en_b;
      prev_sleep = sleep;
   end

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp)
      else begin
         $display("[ERROR] %0t %s is %b, expected %b", $time, name, got, exp);
         errs++;
      end
   endtask

   task automatic check_field(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp)
      else begin
         $display("[ERROR] %0t %s is %h, expected %h", $time, name, got, exp);
         errs++;
      end
   endtask

   task automatic wait_ack(input logic val, output bit ok);
      int n;
      n = 0;
      ok = 1'b1;
      @(negedge clk);
      while (pg_rdy_ack_b !== val) begin
         n++;
         if (n >= TMO) begin
            $display("Timeout: pg_rdy_ack_b never reached %b", val);
            ok = 1'b0;
            return;
         end
         @(negedge clk);
      end
   endtask

   task automatic wait_dfx(input logic [1:0] st, output bit ok);
      int n;
      n = 0;
      ok = 1'b1;
      @(negedge clk);
      while (visa[5:4] !== st) begin
         n++;
         if (n >= TMO) begin
            $display("Timeout: DFx sequencer never reached state %0d", st);
            ok = 1'b0;
            return;
         end
         @(negedge clk);
      end
   endtask

   function automatic bit in_order(input int a, input int b, input int c);
      return (a >= 0) && (a < b) && (b < c);
   endfunction

   // Powered-on values of every output
   task automatic check_on();
      check_bit("pok", pok, 1'b1);
      check_bit("isol_en_b", isol_en_b, 1'b1);
      check_bit("force_rst_b", force_rst_b, 1'b1);
      check_bit("sleep", sleep, 1'b0);
      check_bit("isol_latchen", isol_latchen, 1'b0);
      check_bit("pmc_pg_req_b", pmc_pg_req_b, 1'b1);
      check_bit("pg_rdy_ack_b", pg_rdy_ack_b, 1'b1);
      check_bit("idle", idle, 1'b1);
      check_bit("pwrgate_active", pwrgate_active, 1'b0);
      check_bit("fet_en_b", fet_en_b, 1'b0);
      // State field reads ST_ON, DFx field reads DFX_ON
      check_field("visa state", visa[3:0], 16'd0);
      check_field("visa dfx state", visa[5:4], 16'd3);
      check_field("visa spare bits", visa[15:12], 16'd0);
   endtask

   task automatic run_flow(input row_t r, output bit ok);
      logic warm;
      warm = (r.ptype == 2'd1);
      @(posedge clk);
      #1;
      t_rst_fall = -1;
      t_isol_fall = -1;
      t_sleep_rise = -1;
      req_seen = 1'b0;
      sleep_seen = 1'b0;
      active_seen = 1'b0;
      ip_pg_rdy_req_b = 1'b0;
      wait_ack(1'b0, ok);
      if (!ok) return;
      // Settled off
      check_bit("sleep", sleep, r.exp[5]);
      check_bit("isol_en_b", isol_en_b, r.exp[4]);
      check_bit("force_rst_b", force_rst_b, r.exp[3]);
      check_bit("pok", pok, r.exp[2]);
      check_bit("isol_latchen", isol_latchen, r.exp[1]);
      check_bit("idle", idle, 1'b1);
      check_bit("fet_en_b", fet_en_b, pmc_fet_en_b);
      // Flow was busy on the way down, quiet again once off
      check_bit("pwrgate_active seen", active_seen, 1'b1);
      check_bit("pwrgate_active", pwrgate_active, 1'b0);
      // PMC request held low while gated, never raised for warm
      check_bit("pmc_pg_req_b", pmc_pg_req_b, warm);
      // ST_OFF is the sixth state
      check_field("visa state", visa[3:0], 16'd5);
      if (warm) begin
         check_bit("warm pmc request seen", req_seen, 1'b0);
         check_bit("warm sleep seen", sleep_seen, 1'b0);
      end
      @(posedge clk);
      #1;
      check_bit("down order", warm ? in_order(t_rst_fall, t_isol_fall, t_isol_fall + 1) :
                in_order(t_rst_fall, t_isol_fall, t_sleep_rise), 1'b1);
      t_sleep_fall = -1;
      t_isol_rise = -1;
      t_rst_rise = -1;
      ip_pg_rdy_req_b = 1'b1;
      wait_ack(1'b1, ok);
      if (!ok) return;
      check_on();
      @(posedge clk);
      check_bit("up order", warm ? in_order(t_isol_rise, t_rst_rise, t_rst_rise + 1) :
                in_order(t_sleep_fall, t_isol_rise, t_rst_rise), 1'b1);
   endtask

   initial begin
      bit   ok;
      int   e0;
      row_t r;
      void'($urandom(32'hf58a9e52));
      rst_n = 1'b0;
      ip_pg_rdy_req_b = 1'b1;
      ip_pg_type = 2'd3;
      pmc_pg_ack_b = 1'b1;
      pmc_fet_en_b = 1'b0;
      {cfg_trstdown, cfg_tisolate, cfg_tsleepact} = '0;
      {cfg_tsleepinactiv, cfg_tdeisolate, cfg_trstup} = '0;
      {fdfx_bypass, fdfx_ovr, fscan_mode} = '0;
      {fscan_isol_ctrl, fscan_isol_lat_ctrl, fscan_ret_ctrl} = '0;
      //       mode  type  rnd cfg             byp   ovr   scan    expected
      rows[0] = {2'd0, 2'd3, 1'b0, 12'b000100010001, 2'b00, 3'b000, 6'b100000};
      rows[1] = {2'd0, 2'd0, 1'b0, 12'b010010000100, 2'b00, 3'b000, 6'b100010};
      rows[2] = {2'd0, 2'd1, 1'b0, 12'b000000000000, 2'b00, 3'b000, 6'b000000};
      rows[3] = {2'd0, 2'd2, 1'b1, 12'b000000000000, 2'b00, 3'b000, 6'b100000};
      rows[4] = {2'd0, 2'd0, 1'b1, 12'b000000000000, 2'b00, 3'b000, 6'b100010};
      rows[5] = {2'd0, 2'd3, 1'b1, 12'b000000000000, 2'b00, 3'b000, 6'b100000};
      rows[6] = {2'd1, 2'd3, 1'b0, 12'b000000000000, 2'b10, 3'b000, 6'b100001};
      rows[7] = {2'd1, 2'd3, 1'b0, 12'b000000000000, 2'b11, 3'b000, 6'b011100};
      rows[8] = {2'd2, 2'd3, 1'b0, 12'b000000000000, 2'b00, 3'b011, 6'b000000};
      rows[9] = {2'd2, 2'd3, 1'b0, 12'b000000000000, 2'b00, 3'b100, 6'b000000};
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      e0 = errs;
      check_on();
      $display("reset values: %s", (errs == e0) ? "ok" : "mismatch");
      if (errs == e0) begin
         passes++;
      end else begin
         fails++;
      end

      // ----------------------------
      // Table loop
      // ----------------------------
      foreach (rows[i]) begin
         r = rows[i];
         e0 = errs;
         ok = 1'b1;
         if (r.rnd) begin
            for (int k = 0; k < 6; k++) r.cfg[2*k +: 2] = $urandom_range(0, 3);
         end
         @(posedge clk);
         #1;
         ip_pg_type = r.ptype;
         {cfg_trstdown, cfg_tisolate, cfg_tsleepact} = r.cfg[11:6];
         {cfg_tsleepinactiv, cfg_tdeisolate, cfg_trstup} = r.cfg[5:0];
         if (r.mode == FLOW) begin
            run_flow(r, ok);
         end else if (r.mode == DFX) begin
            fdfx_bypass = r.byp;
            fdfx_ovr = r.ovr;
            wait_dfx(r.ovr ? 2'd3 : 2'd0, ok);
            if (ok) begin
               check_bit("sleep", sleep, r.exp[5]);
               check_bit("isol_en_b", isol_en_b, r.exp[4]);
               check_bit("force_rst_b", force_rst_b, r.exp[3]);
               check_bit("pok", pok, r.exp[2]);
               check_bit("fet_en_b", fet_en_b, r.exp[0]);
               // Gate flow shown as active until the sequencer is back at DFX_ON
               check_bit("pwrgate_active", pwrgate_active, !r.ovr);
            end
            if (r.ovr) begin
               @(posedge clk);
               #1;
               fdfx_bypass = 1'b0;
            end
         end else if (r.mode == SCAN) begin
            fscan_mode = 1'b1;
            {fscan_isol_ctrl, fscan_isol_lat_ctrl, fscan_ret_ctrl} = r.scn;
            repeat (2) @(negedge clk);
            check_bit("sleep", sleep, r.scn[0]);
            check_bit("isol_en_b", isol_en_b, r.scn[2]);
            check_bit("isol_latchen", isol_latchen, r.scn[1]);
            @(posedge clk);
            #1;
            fscan_mode = 1'b0;
         end
         $display("row %0d mode %0d: %s", i, r.mode,
                  (ok && errs == e0) ? "ok" : "failed");
         if (ok && errs == e0) begin
            passes++;
         end else begin
            fails++;
         end
      end
      $display("rows passed %0d, failed %0d", passes, fails);
      if (fails == 0 && errs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
source/pg_types_pkg.sv
source/pg_timing_pkg.sv
source/pg_delay_timer.sv
source/pg_seq_fsm.sv
source/pg_dfx_ovr.sv
source/pg_unit.sv
tests/pg_unit_chk.sv
tests/pg_unit_tb.sv
